/* logic/board_pkg.sv */
// shared widths, privilege codes and segment glyphs that every board status block imports
package board_pkg;

    typedef logic [31:0] word_t;    // pc, instruction, display value, retired count
    typedef logic [63:0] count_t;
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  seg_t;     // active high with the decimal point in bit 7
    typedef logic [7:0]  anode_t;   // one-cold
    typedef logic [3:0]  nibble_t;
    typedef logic [1:0]  priv_t;

    localparam int N_DIGITS = 8;

    localparam priv_t PRIV_U = 2'd0;
    localparam priv_t PRIV_S = 2'd1;
    localparam priv_t PRIV_M = 2'd3;

    // splash word reads "ArchProc" from digit 7 down to digit 0
    localparam seg_t SPLASH_GLYPHS [N_DIGITS] = '{
        8'b00001101, 8'b00011101, 8'b00000101, 8'b01100111,
        8'b00010111, 8'b00001101, 8'b00000101, 8'b01110111
    };

    // seven blanks, "Loading", then two dots
    localparam seg_t LOAD_BANNER [16] = '{
        8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
        8'b00001110, 8'b00011101, 8'b01111101, 8'b00111101,
        8'b00010000, 8'b00010101, 8'b11111011,
        8'b10000000, 8'b10000000
    };

    function automatic seg_t hex_glyph(input nibble_t value);
        case (value)
            4'h0: hex_glyph = 8'b01111110;
            4'h1: hex_glyph = 8'b00110000;
            4'h2: hex_glyph = 8'b01101101;
            4'h3: hex_glyph = 8'b01111001;
            4'h4: hex_glyph = 8'b00110011;
            4'h5: hex_glyph = 8'b01011011;
            4'h6: hex_glyph = 8'b01011111;
            4'h7: hex_glyph = 8'b01110000;
            4'h8: hex_glyph = 8'b01111111;
            4'h9: hex_glyph = 8'b01111011;
            4'ha: hex_glyph = 8'b01110111;
            4'hb: hex_glyph = 8'b00011111;
            4'hc: hex_glyph = 8'b01001110;
            4'hd: hex_glyph = 8'b00111101;
            4'he: hex_glyph = 8'b01001111;
            default: hex_glyph = 8'b01000111;  // f
        endcase
    endfunction

endpackage

/* logic/seg7_scan.sv */
// eight-digit seven-segment scanner instantiated in the board status top for splash, banner and hex display
`timescale 1ns/1ns

module seg7_scan #(
    parameter int SCAN_DIV      = 16000,
    parameter int LOAD_STEP_DIV = 2**25
) (
    input  logic             CORE_CLK,
    input  logic             CORE_RST_X,
    input  logic             init_done,
    input  logic             loading,
    input  board_pkg::word_t disp_value,
    output board_pkg::seg_t  sg,
    output board_pkg::anode_t an
);

    import board_pkg::*;

    localparam int SCAN_W  = $clog2(SCAN_DIV + 1);
    localparam int STEP_W  = $clog2(LOAD_STEP_DIV + 1);
    localparam int DIGIT_W = $clog2(N_DIGITS);

    logic [SCAN_W-1:0]  scan_cnt;
    logic               scan_tick;
    logic [DIGIT_W-1:0] digit;       // digit lit at the next tick
    logic [STEP_W-1:0]  step_cnt;
    logic [3:0]         banner_ofs;
    logic [3:0]         banner_idx;
    nibble_t            nibble;
    seg_t               seg_src;

    assign scan_tick = (scan_cnt == '0);

    // digit prescaler
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            scan_cnt <= '0;
        end else if (scan_cnt == SCAN_W'(SCAN_DIV - 1)) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // banner scroll only counts while the image loads
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            step_cnt   <= '0;
            banner_ofs <= '0;
        end else if (loading) begin
            if (step_cnt == STEP_W'(LOAD_STEP_DIV - 1)) begin
                step_cnt   <= '0;
                banner_ofs <= banner_ofs + 1'b1;
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    assign banner_idx = banner_ofs + 4'd7 - 4'(digit);  // wraps mod 16
    assign nibble     = disp_value[4*digit +: 4];

    always_comb begin
        if (loading) begin
            seg_src = LOAD_BANNER[banner_idx];
        end else if (init_done) begin
            seg_src = hex_glyph(nibble);
        end else begin
            seg_src = SPLASH_GLYPHS[digit];
        end
    end

    // anode and cathodes move together at the slot start
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            sg    <= '1;
            an    <= '1;
            digit <= '0;
        end else if (scan_tick) begin
            an    <= ~(anode_t'(1) << digit);
            sg    <= ~seg_src;        // pins are active low
            digit <= digit + 1'b1;
        end
    end

endmodule

/* logic/display_source.sv */
// picks the word shown on the display from the buttons and keeps the kbd/mouse byte history
`timescale 1ns/1ns

module display_source (
    input  logic             CORE_CLK,
    input  logic             CORE_RST_X,
    input  logic             btn_u,
    input  logic             btn_d,
    input  logic             btn_l,
    input  logic             btn_r,
    input  logic             btn_c,
    input  board_pkg::word_t core_pc,
    input  board_pkg::word_t core_ir,
    input  logic             kbd_we,
    input  logic             mouse_we,
    input  board_pkg::byte_t kbd_data,
    input  board_pkg::byte_t mouse_data,
    output board_pkg::word_t disp_value
);

    import board_pkg::*;

    word_t hist;
    word_t hist_next;

    // bytes 1:0 keyboard, bytes 3:2 mouse, newest in the low byte of each pair
    always_comb begin
        hist_next = hist;
        if (kbd_we) begin
            hist_next[7:0]  = kbd_data;
            hist_next[15:8] = hist[7:0];
        end
        if (mouse_we) begin
            hist_next[23:16] = mouse_data;
            hist_next[31:24] = hist[23:16];
        end
    end

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            hist       <= '0;
            disp_value <= '0;
        end else begin
            hist <= hist_next;
            if (btn_u || btn_d || btn_c) begin
                disp_value <= '0;
            end else if (btn_l) begin
                disp_value <= core_pc;
            end else if (btn_r) begin
                disp_value <= core_ir;
            end else begin
                disp_value <= hist_next;  // same cycle as the history update
            end
        end
    end

endmodule

/* logic/run_monitor.sv */
// load flag, stop latch, heartbeat and the load/run cycle counters
`timescale 1ns/1ns

module run_monitor #(
    parameter int               HEARTBEAT_DIV = 32000000,
    parameter board_pkg::word_t RUN_TIMEOUT   = 32'd500000000
) (
    input  logic              CORE_CLK,
    input  logic              CORE_RST_X,
    input  logic              init_start,
    input  logic              init_done,
    input  logic              btn_c,
    input  logic              halt,
    input  logic              finish,
    input  board_pkg::word_t  inst_cnt,
    output logic              loading,
    output logic              stopped,
    output logic              heartbeat,
    output board_pkg::word_t  init_cycles,
    output board_pkg::count_t run_cycles
);

    localparam int HB_W = $clog2(HEARTBEAT_DIV + 1);

    logic [HB_W-1:0] hb_cnt;
    logic            stop_hit;

    assign stop_hit = btn_c || halt || finish || (inst_cnt > RUN_TIMEOUT);

    // boot image load window
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            loading     <= 1'b0;
            init_cycles <= '0;
        end else begin
            if (!loading && init_start && !init_done) begin
                loading <= 1'b1;
            end else if (init_done) begin
                loading <= 1'b0;
            end
            if (loading) begin
                init_cycles <= init_cycles + 1'b1;
            end
        end
    end

    // sticky until reset
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            stopped    <= 1'b0;
            run_cycles <= '0;
        end else begin
            if (stop_hit) begin
                stopped <= 1'b1;
            end
            if (init_done && !stopped) begin
                run_cycles <= run_cycles + 1'b1;
            end
        end
    end

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            hb_cnt    <= '0;
            heartbeat <= 1'b0;
        end else if (hb_cnt == HB_W'(HEARTBEAT_DIV - 1)) begin
            hb_cnt    <= '0;
            heartbeat <= ~heartbeat;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
        end
    end

endmodule

/* logic/rgb_status.sv */
// tri-colour LED driver that breathes during init and then blinks the privilege colour
`timescale 1ns/1ns

module rgb_status #(
    parameter int PWM_BITS = 12
) (
    input  logic             CORE_CLK,
    input  logic             CORE_RST_X,
    input  logic             init_done,
    input  board_pkg::priv_t priv,
    output logic             led_b,
    output logic             led_g,
    output logic             led_r
);

    import board_pkg::*;

    localparam int ACC_W = PWM_BITS + 1;  // top bit picks ramp up or down
    localparam logic [ACC_W-1:0] G_PHASE = ACC_W'(1 << (PWM_BITS - 2));
    localparam logic [ACC_W-1:0] R_PHASE = ACC_W'(1 << (PWM_BITS - 1));

    logic [PWM_BITS-1:0] ramp;
    logic [ACC_W-1:0]    acc_b;
    logic [ACC_W-1:0]    acc_g;
    logic [ACC_W-1:0]    acc_r;
    logic [3:0]          blink_cnt;
    logic [2:0]          flash_bgr;

    function automatic logic breathe(input logic [ACC_W-1:0] acc,
                                     input logic [PWM_BITS-1:0] level);
        if (acc[ACC_W-1]) begin
            breathe = acc[PWM_BITS-1:0] < level;
        end else begin
            breathe = acc[PWM_BITS-1:0] >= level;
        end
    endfunction

    always_comb begin
        case (priv)
            PRIV_U:  flash_bgr = 3'b100;  // blue
            PRIV_S:  flash_bgr = 3'b010;
            PRIV_M:  flash_bgr = 3'b001;  // red
            default: flash_bgr = 3'b000;
        endcase
    end

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            ramp      <= '0;
            acc_b     <= '0;
            acc_g     <= G_PHASE;
            acc_r     <= R_PHASE;
            blink_cnt <= '0;
            {led_b, led_g, led_r} <= 3'b000;
        end else begin
            ramp      <= ramp + 1'b1;
            blink_cnt <= blink_cnt + 1'b1;
            if (ramp == '1) begin  // different steps keep the colours drifting apart
                acc_b <= acc_b + ACC_W'(2);
                acc_g <= acc_g + ACC_W'(3);
                acc_r <= acc_r + ACC_W'(5);
            end
            if (!init_done) begin
                {led_b, led_g, led_r} <= {breathe(acc_b, ramp), breathe(acc_g, ramp),
                                          breathe(acc_r, ramp)};
            end else if (blink_cnt == 4'd0) begin
                {led_b, led_g, led_r} <= flash_bgr;
            end else begin
                {led_b, led_g, led_r} <= 3'b000;
            end
        end
    end

endmodule

/* logic/board_status_top.sv */
// board status top level that wires the display, run monitor and tri-colour LED and drives the LED bar
`timescale 1ns/1ns

module board_status_top #(
    parameter int               SCAN_DIV      = 16000,
    parameter int               LOAD_STEP_DIV = 2**25,
    parameter int               HEARTBEAT_DIV = 32000000,
    parameter board_pkg::word_t RUN_TIMEOUT   = 32'd500000000,
    parameter int               PWM_BITS      = 12
) (
    input  logic              CORE_CLK,
    input  logic              CORE_RST_X,
    input  logic              init_start,
    input  logic              init_done,
    input  board_pkg::priv_t  priv,
    input  board_pkg::word_t  core_pc,
    input  board_pkg::word_t  core_ir,
    input  board_pkg::word_t  inst_cnt,
    input  logic              kbd_we,
    input  logic              mouse_we,
    input  board_pkg::byte_t  kbd_data,
    input  board_pkg::byte_t  mouse_data,
    input  logic              btn_u,
    input  logic              btn_d,
    input  logic              btn_l,
    input  logic              btn_r,
    input  logic              btn_c,
    input  logic              halt,
    input  logic              finish,
    output board_pkg::seg_t   sg,
    output board_pkg::anode_t an,
    output logic [15:0]       led,
    output logic              led_b,
    output logic              led_g,
    output logic              led_r,
    output board_pkg::word_t  init_cycles,
    output board_pkg::count_t run_cycles
);

    import board_pkg::*;

    word_t disp_value;
    logic  loading;
    logic  stopped;
    logic  heartbeat;

    assign led = {12'd0, loading, stopped, init_done, heartbeat};

    seg7_scan #(
        .SCAN_DIV      (SCAN_DIV),
        .LOAD_STEP_DIV (LOAD_STEP_DIV)
    ) seg7_scan_i (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X),
        .init_done  (init_done),
        .loading    (loading),
        .disp_value (disp_value),
        .sg         (sg),
        .an         (an)
    );

    display_source display_source_i (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X),
        .btn_u      (btn_u),
        .btn_d      (btn_d),
        .btn_l      (btn_l),
        .btn_r      (btn_r),
        .btn_c      (btn_c),
        .core_pc    (core_pc),
        .core_ir    (core_ir),
        .kbd_we     (kbd_we),
        .mouse_we   (mouse_we),
        .kbd_data   (kbd_data),
        .mouse_data (mouse_data),
        .disp_value (disp_value)
    );

    run_monitor #(
        .HEARTBEAT_DIV (HEARTBEAT_DIV),
        .RUN_TIMEOUT   (RUN_TIMEOUT)
    ) run_monitor_i (
        .CORE_CLK    (CORE_CLK),
        .CORE_RST_X  (CORE_RST_X),
        .init_start  (init_start),
        .init_done   (init_done),
        .btn_c       (btn_c),
        .halt        (halt),
        .finish      (finish),
        .inst_cnt    (inst_cnt),
        .loading     (loading),
        .stopped     (stopped),
        .heartbeat   (heartbeat),
        .init_cycles (init_cycles),
        .run_cycles  (run_cycles)
    );

    rgb_status #(
        .PWM_BITS (PWM_BITS)
    ) rgb_status_i (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X),
        .init_done  (init_done),
        .priv       (priv),
        .led_b      (led_b),
        .led_g      (led_g),
        .led_r      (led_r)
    );

endmodule

/* bench/tb_board_tasks.svh */
// directed tests for the board status block to be included inside the testbench module

    task automatic idle_inputs();
        init_start <= 1'b0;
        init_done  <= 1'b0;
        priv       <= PRIV_U;
        core_pc    <= '0;
        core_ir    <= '0;
        inst_cnt   <= '0;
        kbd_we     <= 1'b0;
        mouse_we   <= 1'b0;
        kbd_data   <= '0;
        mouse_data <= '0;
        {btn_u, btn_d, btn_l, btn_r, btn_c} <= 5'b0;
        halt       <= 1'b0;
        finish     <= 1'b0;
    endtask

    // holds reset for three cycles and returns at the falling edge after release
    task automatic apply_reset();
        @(posedge CORE_CLK);
        CORE_RST_X <= 1'b0;
        idle_inputs();
        repeat (2) @(posedge CORE_CLK);
        @(negedge CORE_CLK);
        if (sg !== '1 || an !== '1 || led !== '0 || rgb !== '0 ||
                init_cycles !== '0 || run_cycles !== '0) begin
            flag_mismatch($sformatf("outputs not idle in reset, sg=%h an=%h led=%h",
                                    sg, an, led));
        end
        @(posedge CORE_CLK);
        CORE_RST_X <= 1'b1;
        @(negedge CORE_CLK);
    endtask

    function automatic int cold_index(input anode_t value);
        int idx;
        idx = -1;
        for (int i = 0; i < N_DIGITS; i++) begin
            if (value == ~(anode_t'(1) << i)) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // waits for the next digit slot from a falling edge
    task automatic wait_slot(output int digit, output int gap);
        anode_t prev;
        prev  = an;
        gap   = 0;
        digit = -1;
        while (an === prev && gap <= 2 * SCAN_DIV) begin
            @(negedge CORE_CLK);
            gap++;
        end
        if (an === prev) begin
            $display("Scanner stalled: no digit change within %0d cycles at t=%0t", gap, $time);
            err_count++;
        end else begin
            digit = cold_index(an);
            if (digit < 0) begin
                flag_mismatch($sformatf("anode %b is not one-cold", an));
            end
        end
    endtask

    task automatic check_hex_scan(input word_t value);
        int digit;
        int gap;
        repeat (N_DIGITS) begin
            wait_slot(digit, gap);
            if (digit >= 0 && sg !== ~HEX_SEGMENTS[value[4*digit +: 4]]) begin
                flag_mismatch($sformatf("digit %0d of %h shows sg=%b", digit, value, sg));
            end
        end
    endtask

    task automatic splash_scan_test();
        int digit;
        int gap;
        start_test("splash scan");
        apply_reset();
        rgb_toggles = '{0, 0, 0};
        for (int s = 0; s < N_DIGITS; s++) begin
            wait_slot(digit, gap);
            if (digit != s || (s > 0 && gap != SCAN_DIV)) begin
                flag_mismatch($sformatf("slot %0d lit digit %0d after %0d cycles", s, digit, gap));
            end
            if (digit >= 0 && sg !== ~SPLASH_GLYPHS[digit]) begin
                flag_mismatch($sformatf("splash digit %0d shows sg=%b", digit, sg));
            end
        end
        for (int i = 0; i < 3; i++) begin
            if (rgb_toggles[i] == 0) begin
                flag_mismatch($sformatf("colour %0d never toggled while breathing", i));
            end
        end
        report_test();
    endtask

    task automatic banner_test();
        anode_t prev_an;
        int     k;
        int     slots;
        start_test("loading banner");
        apply_reset();
        slots = 0;
        @(posedge CORE_CLK);
        init_start <= 1'b1;
        @(negedge CORE_CLK);
        if (led[3] !== 1'b0) begin
            flag_mismatch("loading rose in the same cycle as init_start");
        end
        prev_an = an;
        // x counts rising edges after the one that drove init_start
        for (int x = 1; x <= 80; x++) begin
            @(negedge CORE_CLK);
            if (led[3] !== 1'b1) begin
                flag_mismatch($sformatf("loading low at edge %0d", x));
            end
            if (an !== prev_an && x >= 2) begin
                k = cold_index(an);
                // offset is one step per LOAD_STEP_DIV edges with loading high
                if (k < 0 ||
                        sg !== ~LOAD_BANNER[((x - 2) / LOAD_STEP_DIV + 7 - k) % 16]) begin
                    flag_mismatch($sformatf("banner edge %0d digit %0d sg=%b", x, k, sg));
                end
                slots++;
            end
            prev_an = an;
        end
        @(posedge CORE_CLK);    // edge 81
        init_done  <= 1'b1;
        init_start <= 1'b0;
        repeat (2) @(negedge CORE_CLK);
        if (led[3] !== 1'b0) begin
            flag_mismatch("loading still high after init_done");
        end
        repeat (4) @(negedge CORE_CLK);
        // loading was high at edges 2 to 82
        if (init_cycles !== 32'd81 || slots < 16) begin
            flag_mismatch($sformatf("init_cycles %0d, %0d banner slots", init_cycles, slots));
        end
        report_test();
    endtask

    task automatic hex_display_test();
        logic [4:0]  combos [8] = '{5'b00100, 5'b00010, 5'b10000, 5'b01000,
                                    5'b00001, 5'b00110, 5'b10100, 5'b00000};
        word_t       hist;
        word_t       pc;
        word_t       ir;
        word_t       shown;
        logic [31:0] r;
        start_test("hex display");
        apply_reset();
        hist = '0;
        @(posedge CORE_CLK);
        init_done <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            @(posedge CORE_CLK);
            r = lcg_next();
            kbd_we     <= r[0] || i == 0;
            mouse_we   <= r[1] || i == 0;
            kbd_data   <= r[15:8];
            mouse_data <= r[23:16];
            if (r[0] || i == 0) begin
                hist[15:0] = {hist[7:0], r[15:8]};     // older byte moves up
            end
            if (r[1] || i == 0) begin
                hist[31:16] = {hist[23:16], r[23:16]};
            end
        end
        @(posedge CORE_CLK);
        kbd_we   <= 1'b0;
        mouse_we <= 1'b0;
        repeat (2) @(negedge CORE_CLK);
        check_hex_scan(hist);
        pc = lcg_next();
        ir = lcg_next();
        for (int i = 0; i < 8; i++) begin
            @(posedge CORE_CLK);
            core_pc <= pc;
            core_ir <= ir;
            {btn_u, btn_d, btn_l, btn_r, btn_c} <= combos[i];
            // u, d and c blank the value, then l, then r
            shown = (combos[i][4] || combos[i][3] || combos[i][0]) ? '0 :
                    combos[i][2] ? pc : combos[i][1] ? ir : hist;
            repeat (2) @(negedge CORE_CLK);
            check_hex_scan(shown);
        end
        report_test();
    endtask

    task automatic stop_latch_test();
        count_t snap;
        start_test("stop latch");
        for (int trig = 0; trig < 4; trig++) begin
            apply_reset();
            @(posedge CORE_CLK);
            init_done <= 1'b1;
            inst_cnt  <= (trig == 3) ? RUN_TIMEOUT : '0;  // at the limit but not above
            repeat (4) @(negedge CORE_CLK);
            snap = run_cycles;
            repeat (3) @(negedge CORE_CLK);
            if (run_cycles !== snap + 3 || led[2] !== 1'b0) begin
                flag_mismatch($sformatf("trigger %0d: run_cycles %0d from %0d, stopped %b",
                                        trig, run_cycles, snap, led[2]));
            end
            @(posedge CORE_CLK);
            case (trig)
                0: btn_c <= 1'b1;
                1: halt <= 1'b1;
                2: finish <= 1'b1;
                default: inst_cnt <= RUN_TIMEOUT + 1;
            endcase
            @(negedge CORE_CLK);
            if (led[2] !== 1'b0) begin
                flag_mismatch($sformatf("trigger %0d: stopped rose too early", trig));
            end
            @(negedge CORE_CLK);
            if (led[2] !== 1'b1) begin
                flag_mismatch($sformatf("trigger %0d: stopped did not rise", trig));
            end
            snap = run_cycles;
            @(posedge CORE_CLK);
            idle_inputs();
            init_done <= 1'b1;
            repeat (5) @(negedge CORE_CLK);
            if (led[2] !== 1'b1 || run_cycles !== snap) begin
                flag_mismatch($sformatf("trigger %0d: latch lost or run_cycles moved to %0d",
                                        trig, run_cycles));
            end
        end
        report_test();
    endtask

    task automatic priv_flash_test();
        priv_t      codes [4] = '{PRIV_U, PRIV_S, PRIV_M, 2'd2};
        int         lit [3];
        logic [2:0] want;
        start_test("privilege flash");
        apply_reset();
        @(posedge CORE_CLK);
        init_done <= 1'b1;
        foreach (codes[c]) begin
            @(posedge CORE_CLK);
            priv <= codes[c];
            repeat (2) @(negedge CORE_CLK);
            lit = '{0, 0, 0};
            repeat (64) begin
                @(negedge CORE_CLK);
                for (int i = 0; i < 3; i++) begin
                    lit[i] += rgb[i];
                end
            end
            want = (codes[c] == PRIV_U) ? 3'b001 : (codes[c] == PRIV_S) ? 3'b010 :
                   (codes[c] == PRIV_M) ? 3'b100 : 3'b000;
            for (int i = 0; i < 3; i++) begin
                if (lit[i] != (want[i] ? 4 : 0)) begin
                    flag_mismatch($sformatf("priv %0d colour %0d lit in %0d of 64 cycles",
                                            codes[c], i, lit[i]));
                end
            end
        end
        report_test();
    endtask

    task automatic heartbeat_led_test();
        logic prev;
        int   gap;
        start_test("heartbeat and led bar");
        apply_reset();
        for (int n = 0; n < 4; n++) begin
            prev = led[0];
            gap  = 0;
            while (led[0] === prev && gap <= 2 * HEARTBEAT_DIV) begin
                @(negedge CORE_CLK);
                gap++;
            end
            if (led[0] === prev) begin
                $display("Heartbeat stuck: no toggle within %0d cycles at t=%0t", gap, $time);
                err_count++;
            end else if (n > 0 && gap != HEARTBEAT_DIV) begin
                flag_mismatch($sformatf("heartbeat toggled after %0d cycles", gap));
            end
        end
        for (int v = 0; v < 4; v++) begin
            @(posedge CORE_CLK);
            init_done <= v[0];
            @(negedge CORE_CLK);
            if (led[1] !== v[0] || led[15:4] !== '0) begin
                flag_mismatch($sformatf("led %h with init_done %b", led, v[0]));
            end
        end
        report_test();
    endtask

/* bench/tb_board_status.sv */
// testbench top for the board status block that runs the directed tests and prints the summary
`timescale 1ns/1ns

module tb_board_status;

    import board_pkg::*;

    localparam int    SCAN_DIV      = 4;
    localparam int    LOAD_STEP_DIV = 8;
    localparam int    HEARTBEAT_DIV = 10;
    localparam word_t RUN_TIMEOUT   = 32'd100;
    localparam int    PWM_BITS      = 4;
    localparam int    TIMEOUT_CYCLES = 4000;  // the full test list takes roughly 900 cycles

    // seven-segment patterns for hex digits 0 to f with segment a in bit 6
    localparam logic [7:0] HEX_SEGMENTS [16] = '{
        8'h7e, 8'h30, 8'h6d, 8'h79, 8'h33, 8'h5b, 8'h5f, 8'h70,
        8'h7f, 8'h7b, 8'h77, 8'h1f, 8'h4e, 8'h3d, 8'h4f, 8'h47
    };

    logic        CORE_CLK;
    logic        CORE_RST_X;
    logic        init_start, init_done;
    priv_t       priv;
    word_t       core_pc, core_ir, inst_cnt;
    logic        kbd_we, mouse_we;
    byte_t       kbd_data, mouse_data;
    logic        btn_u, btn_d, btn_l, btn_r, btn_c;
    logic        halt, finish;
    seg_t        sg;
    anode_t      an;
    logic [15:0] led;
    logic        led_b, led_g, led_r;
    word_t       init_cycles;
    count_t      run_cycles;

    logic [2:0]  rgb;        // bit 0 blue, bit 1 green, bit 2 red
    logic [2:0]  rgb_prev;
    int          rgb_toggles [3];
    logic [31:0] lcg_state = 32'he6d8;
    int          cycle_cnt = 0;
    int          err_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errs_at_start;
    string       test_name;

    assign rgb = {led_r, led_g, led_b};

    initial begin
        CORE_CLK = 1'b0;
        forever #10 CORE_CLK = ~CORE_CLK;
    end

    always @(posedge CORE_CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // edges seen on each colour for the breathing check
    always @(negedge CORE_CLK) begin
        for (int i = 0; i < 3; i++) begin
            if (rgb[i] !== rgb_prev[i]) begin
                rgb_toggles[i] = rgb_toggles[i] + 1;
            end
        end
        rgb_prev = rgb;
    end

    board_status_top #(
        .SCAN_DIV      (SCAN_DIV),
        .LOAD_STEP_DIV (LOAD_STEP_DIV),
        .HEARTBEAT_DIV (HEARTBEAT_DIV),
        .RUN_TIMEOUT   (RUN_TIMEOUT),
        .PWM_BITS      (PWM_BITS)
    ) board_status_top_i (.*);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic flag_mismatch(input string msg);
        $display("FAIL t=%0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errs_at_start = err_count;
        tests_run++;
    endtask

    task automatic report_test();
        if (err_count == errs_at_start) begin
            $display("PASS %s", test_name);
        end else begin
            $display("FAIL t=%0t: %s, %0d mismatches", $time, test_name,
                     err_count - errs_at_start);
            tests_failed++;
        end
    endtask

    `include "tb_board_tasks.svh"

    initial begin
        CORE_RST_X = 1'b0;
        idle_inputs();
        splash_scan_test();
        banner_test();
        hex_display_test();
        stop_latch_test();
        priv_flash_test();
        heartbeat_led_test();
        $display("Tests run: %0d, failed: %0d, mismatches: %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+bench
logic/board_pkg.sv
logic/seg7_scan.sv
logic/display_source.sv
logic/run_monitor.sv
logic/rgb_status.sv
logic/board_status_top.sv
bench/tb_board_status.sv
